// File: adc_ctrl_pkg.sv
package adc_ctrl_pkg;

    // result and word widths
    localparam int sample_w         = 6;
    localparam int samples_per_word = 16;
    localparam int spi_word_w       = sample_w * samples_per_word;

    // each enable makes the chip answer with this many results
    localparam int samples_per_ena  = 4;

    // timing in clk cycles, scaled down for simulation
    localparam int ena_period       = 25;
    localparam int reset_cycles     = 20;
    localparam int pre_delay_cycles = 50;

    // enables per run
    localparam int calib_enables    = 8;
    localparam int sample_enables   = 16;

    // spi words allowed in flight
    localparam int spi_credits      = 2;
    // one spare code so an extra returned credit can be seen
    localparam int credit_w         = $clog2(spi_credits + 2);

    typedef logic [sample_w-1:0]   sample_t;
    typedef logic [spi_word_w-1:0] spi_word_t;
    typedef logic [8:0]            nowa_t;
    typedef logic [3:0]            cmd_t;
    typedef logic [15:0]           count_t;

    // uart command codes, anything else restarts the adc reset
    localparam cmd_t cmd_calib  = 4'd1;
    localparam cmd_t cmd_sample = 4'd2;

    typedef enum logic [2:0] {
        idle      = 3'd0,
        adc_reset = 3'd1,
        hold      = 3'd2,
        pre_delay = 3'd3,
        calib     = 3'd4,
        sample    = 3'd5
    } seq_state_t;

endpackage

// File: uart_cmd_decoder.sv
`timescale 1ns/1ps

module uart_cmd_decoder (
    input  logic               clk,
    input  logic               nrst,
    input  logic [7:0]         uart_rdata,
    input  logic               uart_vld,
    output adc_ctrl_pkg::cmd_t cmd,
    output logic               cmd_valid
);

    // previous uart_vld for the falling edge
    logic vld_d;

    always_ff @(posedge clk or negedge nrst) begin
        if (!nrst) begin
            vld_d <= 1'b0;
        end else begin
            vld_d <= uart_vld;
        end
    end

    // keep the low nibble of whatever byte is on the bus
    always_ff @(posedge clk or negedge nrst) begin
        if (!nrst) begin
            cmd <= '0;
        end else if (uart_vld) begin
            cmd <= uart_rdata[3:0];
        end
    end

    // byte finished when valid drops, cmd already holds it
    assign cmd_valid = vld_d & ~uart_vld;

endmodule

// File: adc_strobe_gen.sv
`timescale 1ns/1ps

module adc_strobe_gen (
    input  logic                 clk,
    input  logic                 nrst,
    input  logic                 run_start,
    input  logic                 run_active,
    input  adc_ctrl_pkg::count_t run_enables,
    output logic                 adc_ena,
    output logic                 ena_done
);

    adc_ctrl_pkg::count_t per_cnt;
    adc_ctrl_pkg::count_t ena_cnt;

    always_ff @(posedge clk or negedge nrst) begin
        if (!nrst) begin
            per_cnt <= '0;
            ena_cnt <= '0;
            adc_ena <= 1'b0;
        end else if (run_start) begin
            // run_start counts as the first cycle of the period
            per_cnt <= adc_ctrl_pkg::count_t'(1);
            ena_cnt <= '0;
            adc_ena <= 1'b0;
        end else if (run_active && !ena_done) begin
            if (per_cnt == adc_ctrl_pkg::count_t'(adc_ctrl_pkg::ena_period - 1)) begin
                per_cnt <= '0;
                ena_cnt <= ena_cnt + adc_ctrl_pkg::count_t'(1);
                adc_ena <= 1'b1;
            end else begin
                per_cnt <= per_cnt + adc_ctrl_pkg::count_t'(1);
                adc_ena <= 1'b0;
            end
        end else begin
            // count kept until the run ends so ena_done holds
            per_cnt <= '0;
            ena_cnt <= run_active ? ena_cnt : '0;
            adc_ena <= 1'b0;
        end
    end

    assign ena_done = (ena_cnt == run_enables);

    // enable pulses only while the sequencer is in a run state
    a_ena_in_run: assert property (@(posedge clk) disable iff (!nrst) adc_ena |-> run_active)
        else $error("adc_ena outside a run");

endmodule

// File: sample_packer.sv
`timescale 1ns/1ps

module sample_packer (
    input  logic                    clk,
    input  logic                    nrst,
    input  logic                    run_start,
    input  logic                    run_active,
    input  adc_ctrl_pkg::count_t    run_enables,
    input  logic                    adc_ack,
    input  logic                    adc_ack_sub,
    input  adc_ctrl_pkg::sample_t   adc_dout,
    input  logic                    spi_credit,
    output adc_ctrl_pkg::spi_word_t spi_wdata,
    output logic                    spi_wreq,
    output logic                    spi_overrun,
    output logic                    pack_done
);

    logic                              ack_sync;
    logic                              ack_prev;
    adc_ctrl_pkg::sample_t             dout_q;
    adc_ctrl_pkg::spi_word_t           shift_word;
    adc_ctrl_pkg::spi_word_t           full_word;
    adc_ctrl_pkg::spi_word_t           pend_word;
    adc_ctrl_pkg::count_t              word_cnt;
    adc_ctrl_pkg::count_t              sample_cnt;
    adc_ctrl_pkg::count_t              run_total;
    logic                              pending;
    logic [adc_ctrl_pkg::credit_w-1:0] credits;
    logic                              ack_rise;
    logic                              capture;
    logic                              word_done;
    logic                              issue;

    assign run_total = adc_ctrl_pkg::count_t'(run_enables * adc_ctrl_pkg::samples_per_ena);

    // either acknowledge line marks a new result
    assign ack_rise  = ack_sync & ~ack_prev;
    assign capture   = ack_rise && run_active && !run_start && (sample_cnt < run_total);
    assign word_done = capture &&
                       (word_cnt == adc_ctrl_pkg::count_t'(adc_ctrl_pkg::samples_per_word - 1));
    // new result enters at the bottom, oldest ends up in the msbs
    assign full_word = {shift_word[adc_ctrl_pkg::spi_word_w-adc_ctrl_pkg::sample_w-1:0], dout_q};
    // the pending word always goes out before a fresh one
    assign issue     = run_active && (pending || word_done) && (credits != '0);
    assign pack_done = (sample_cnt == run_total) && !pending &&
                       (credits == adc_ctrl_pkg::credit_w'(adc_ctrl_pkg::spi_credits));

    always_ff @(posedge clk or negedge nrst) begin
        if (!nrst) begin
            ack_sync <= 1'b0;
            ack_prev <= 1'b0;
        end else begin
            ack_sync <= adc_ack | adc_ack_sub;
            ack_prev <= ack_sync;
        end
    end

    always_ff @(posedge clk) begin
        dout_q <= adc_dout;
        if (capture) begin
            shift_word <= full_word;
        end
        if (issue) begin
            spi_wdata <= pending ? pend_word : full_word;
        end
        // park a finished word unless it leaves straight away
        if (word_done && (pending == issue)) begin
            pend_word <= full_word;
        end
    end

    always_ff @(posedge clk or negedge nrst) begin
        if (!nrst) begin
            word_cnt    <= '0;
            sample_cnt  <= '0;
            pending     <= 1'b0;
            credits     <= adc_ctrl_pkg::credit_w'(adc_ctrl_pkg::spi_credits);
            spi_wreq    <= 1'b0;
            spi_overrun <= 1'b0;
        end else begin
            spi_wreq <= issue;
            credits  <= credits - adc_ctrl_pkg::credit_w'(issue)
                        + adc_ctrl_pkg::credit_w'(spi_credit);
            if (run_start) begin
                word_cnt    <= '0;
                sample_cnt  <= '0;
                pending     <= 1'b0;
                credits     <= adc_ctrl_pkg::credit_w'(adc_ctrl_pkg::spi_credits);
                spi_overrun <= 1'b0;
            end else if (!run_active) begin
                word_cnt   <= '0;
                sample_cnt <= '0;
                pending    <= 1'b0;
            end else begin
                if (capture) begin
                    sample_cnt <= sample_cnt + adc_ctrl_pkg::count_t'(1);
                    word_cnt   <= word_done ? '0 : word_cnt + adc_ctrl_pkg::count_t'(1);
                end
                if (pending) begin
                    if (issue) begin
                        pending <= word_done;
                    end else if (word_done) begin
                        // second word finished with no room, it is lost
                        spi_overrun <= 1'b1;
                    end
                end else if (word_done && !issue) begin
                    pending <= 1'b1;
                end
            end
        end
    end

    // the spi side must not hand back more credits than it was given
    a_credit_max: assert property (@(posedge clk) disable iff (!nrst)
        credits <= adc_ctrl_pkg::credit_w'(adc_ctrl_pkg::spi_credits))
        else $error("spi credit count above limit");

endmodule

// File: test_sequencer.sv
`timescale 1ns/1ps

module test_sequencer (
    input  logic                     clk,
    input  logic                     nrst,
    input  logic                     pll_locked,
    input  adc_ctrl_pkg::nowa_t      sw_nowa,
    input  adc_ctrl_pkg::cmd_t       cmd,
    input  logic                     cmd_valid,
    input  logic                     ena_done,
    input  logic                     pack_done,
    output logic                     adc_rstn,
    output logic                     adc_calib_ena,
    output adc_ctrl_pkg::nowa_t      adc_nowa,
    output logic                     run_start,
    output logic                     run_active,
    output adc_ctrl_pkg::count_t     run_enables,
    output adc_ctrl_pkg::seq_state_t state
);

    adc_ctrl_pkg::seq_state_t state_n;
    adc_ctrl_pkg::count_t     rst_cnt;
    adc_ctrl_pkg::count_t     pre_cnt;
    adc_ctrl_pkg::cmd_t       cmd_q;
    logic                     rst_last;
    logic                     pre_last;

    assign rst_last = (rst_cnt == adc_ctrl_pkg::count_t'(adc_ctrl_pkg::reset_cycles - 1));
    assign pre_last = (pre_cnt == adc_ctrl_pkg::count_t'(adc_ctrl_pkg::pre_delay_cycles - 1));

    always_comb begin
        state_n = state;
        case (state)
            adc_ctrl_pkg::idle: begin
                state_n = adc_ctrl_pkg::adc_reset;
            end
            adc_ctrl_pkg::adc_reset: begin
                if (rst_last) begin
                    state_n = adc_ctrl_pkg::hold;
                end
            end
            adc_ctrl_pkg::hold: begin
                if (cmd_valid) begin
                    state_n = adc_ctrl_pkg::pre_delay;
                end
            end
            adc_ctrl_pkg::pre_delay: begin
                if (pre_last) begin
                    if (cmd_q == adc_ctrl_pkg::cmd_calib) begin
                        state_n = adc_ctrl_pkg::calib;
                    end else if (cmd_q == adc_ctrl_pkg::cmd_sample) begin
                        state_n = adc_ctrl_pkg::sample;
                    end else begin
                        // unknown command, reset the chip again
                        state_n = adc_ctrl_pkg::adc_reset;
                    end
                end
            end
            adc_ctrl_pkg::calib, adc_ctrl_pkg::sample: begin
                // all enables out, all results in, all words acknowledged
                if (ena_done && pack_done) begin
                    state_n = adc_ctrl_pkg::hold;
                end
            end
            default: begin
                state_n = adc_ctrl_pkg::idle;
            end
        endcase
        // pll loss wins over everything
        if (!pll_locked) begin
            state_n = adc_ctrl_pkg::idle;
        end
    end

    always_ff @(posedge clk or negedge nrst) begin
        if (!nrst) begin
            state       <= adc_ctrl_pkg::idle;
            rst_cnt     <= '0;
            pre_cnt     <= '0;
            cmd_q       <= '0;
            run_start   <= 1'b0;
            run_enables <= '0;
            adc_nowa    <= '0;
        end else begin
            state     <= state_n;
            rst_cnt   <= (state == adc_ctrl_pkg::adc_reset) ?
                         rst_cnt + adc_ctrl_pkg::count_t'(1) : '0;
            pre_cnt   <= (state == adc_ctrl_pkg::pre_delay) ?
                         pre_cnt + adc_ctrl_pkg::count_t'(1) : '0;
            run_start <= (state == adc_ctrl_pkg::pre_delay) &&
                         ((state_n == adc_ctrl_pkg::calib) || (state_n == adc_ctrl_pkg::sample));
            if ((state == adc_ctrl_pkg::hold) && cmd_valid) begin
                cmd_q <= cmd;
            end
            // run length fixed before the run begins
            if (state == adc_ctrl_pkg::pre_delay) begin
                run_enables <= (cmd_q == adc_ctrl_pkg::cmd_calib) ?
                               adc_ctrl_pkg::count_t'(adc_ctrl_pkg::calib_enables) :
                               adc_ctrl_pkg::count_t'(adc_ctrl_pkg::sample_enables);
            end
            // config switches sampled while the chip sits in reset
            if (state == adc_ctrl_pkg::adc_reset) begin
                adc_nowa <= sw_nowa;
            end
        end
    end

    assign adc_rstn      = (state != adc_ctrl_pkg::adc_reset);
    assign adc_calib_ena = (state == adc_ctrl_pkg::calib);
    assign run_active    = (state == adc_ctrl_pkg::calib) || (state == adc_ctrl_pkg::sample);

endmodule

// File: adc_ctrl_top.sv
`timescale 1ns/1ps

module adc_ctrl_top (
    input  logic                     clk,
    input  logic                     nrst,
    input  logic                     pll_locked,
    input  adc_ctrl_pkg::nowa_t      sw_nowa,
    input  logic [7:0]               uart_rdata,
    input  logic                     uart_vld,
    input  logic                     adc_ack,
    input  logic                     adc_ack_sub,
    input  adc_ctrl_pkg::sample_t    adc_dout,
    input  logic                     spi_credit,
    output logic                     adc_rstn,
    output logic                     adc_calib_ena,
    output logic                     adc_ena,
    output adc_ctrl_pkg::nowa_t      adc_nowa,
    output adc_ctrl_pkg::spi_word_t  spi_wdata,
    output logic                     spi_wreq,
    output logic                     spi_overrun,
    output adc_ctrl_pkg::seq_state_t state
);

    adc_ctrl_pkg::cmd_t   cmd;
    logic                 cmd_valid;
    logic                 run_start;
    logic                 run_active;
    adc_ctrl_pkg::count_t run_enables;
    logic                 ena_done;
    logic                 pack_done;

    uart_cmd_decoder u_decoder (
        .clk        (clk),
        .nrst       (nrst),
        .uart_rdata (uart_rdata),
        .uart_vld   (uart_vld),
        .cmd        (cmd),
        .cmd_valid  (cmd_valid)
    );

    test_sequencer u_sequencer (
        .clk           (clk),
        .nrst          (nrst),
        .pll_locked    (pll_locked),
        .sw_nowa       (sw_nowa),
        .cmd           (cmd),
        .cmd_valid     (cmd_valid),
        .ena_done      (ena_done),
        .pack_done     (pack_done),
        .adc_rstn      (adc_rstn),
        .adc_calib_ena (adc_calib_ena),
        .adc_nowa      (adc_nowa),
        .run_start     (run_start),
        .run_active    (run_active),
        .run_enables   (run_enables),
        .state         (state)
    );

    adc_strobe_gen u_strobe (
        .clk         (clk),
        .nrst        (nrst),
        .run_start   (run_start),
        .run_active  (run_active),
        .run_enables (run_enables),
        .adc_ena     (adc_ena),
        .ena_done    (ena_done)
    );

    sample_packer u_packer (
        .clk         (clk),
        .nrst        (nrst),
        .run_start   (run_start),
        .run_active  (run_active),
        .run_enables (run_enables),
        .adc_ack     (adc_ack),
        .adc_ack_sub (adc_ack_sub),
        .adc_dout    (adc_dout),
        .spi_credit  (spi_credit),
        .spi_wdata   (spi_wdata),
        .spi_wreq    (spi_wreq),
        .spi_overrun (spi_overrun),
        .pack_done   (pack_done)
    );

endmodule

// File: adc_ctrl_tb.sv
`timescale 1ns/1ps

module adc_ctrl_tb;

    // cycle budgets per test, used by the watchdog and the wait loops
    localparam int run_slack     = 200;
    localparam int reset_budget  = adc_ctrl_pkg::reset_cycles + 20;
    localparam int pre_budget    = adc_ctrl_pkg::pre_delay_cycles + 10;
    localparam int calib_budget  = pre_budget + adc_ctrl_pkg::calib_enables * adc_ctrl_pkg::ena_period
                                   + run_slack;
    localparam int sample_budget = pre_budget + adc_ctrl_pkg::sample_enables * adc_ctrl_pkg::ena_period
                                   + run_slack;
    localparam int watchdog_cycles = 8 + 2 * reset_budget + pre_budget + calib_budget
                                     + 2 * sample_budget + 500;

    logic                     clk;
    logic                     nrst;
    logic                     pll_locked;
    adc_ctrl_pkg::nowa_t      sw_nowa;
    logic [7:0]               uart_rdata;
    logic                     uart_vld;
    logic                     adc_ack;
    logic                     adc_ack_sub;
    adc_ctrl_pkg::sample_t    adc_dout;
    logic                     spi_credit;
    logic                     adc_rstn;
    logic                     adc_calib_ena;
    logic                     adc_ena;
    adc_ctrl_pkg::nowa_t      adc_nowa;
    adc_ctrl_pkg::spi_word_t  spi_wdata;
    logic                     spi_wreq;
    logic                     spi_overrun;
    adc_ctrl_pkg::seq_state_t state;

    integer                   seed = 32'hc3cd_eaec;
    int                       errors = 0;
    adc_ctrl_pkg::sample_t    exp_q[$];
    adc_ctrl_pkg::sample_t    chip_val;
    adc_ctrl_pkg::spi_word_t  exp_word;
    int                       samples_sent = 0;
    int                       words_seen = 0;
    int                       owed = 0;
    int                       credit_wait = 0;
    logic                     credit_en = 1'b1;
    logic                     exp_calib = 1'b0;
    int                       cyc = 0;
    int                       last_ena = 0;
    int                       ena_seen = 0;
    logic                     in_run = 1'b0;
    logic                     was_run = 1'b0;

    adc_ctrl_top uut (
        .clk           (clk),
        .nrst          (nrst),
        .pll_locked    (pll_locked),
        .sw_nowa       (sw_nowa),
        .uart_rdata    (uart_rdata),
        .uart_vld      (uart_vld),
        .adc_ack       (adc_ack),
        .adc_ack_sub   (adc_ack_sub),
        .adc_dout      (adc_dout),
        .spi_credit    (spi_credit),
        .adc_rstn      (adc_rstn),
        .adc_calib_ena (adc_calib_ena),
        .adc_ena       (adc_ena),
        .adc_nowa      (adc_nowa),
        .spi_wdata     (spi_wdata),
        .spi_wreq      (spi_wreq),
        .spi_overrun   (spi_overrun),
        .state         (state)
    );

    always #5 clk = ~clk;

    task automatic compare_word(input adc_ctrl_pkg::spi_word_t got,
                                input adc_ctrl_pkg::spi_word_t exp, input string what);
        if (got !== exp) begin
            $display("MISMATCH at %0t: %s got %h expected %h", $time, what, got, exp);
            errors = errors + 1;
        end
    endtask

    task automatic compare_state(input adc_ctrl_pkg::seq_state_t got,
                                 input adc_ctrl_pkg::seq_state_t exp, input string what);
        if (got !== exp) begin
            $display("MISMATCH at %0t: %s got %s expected %s", $time, what, got.name(),
                     exp.name());
            errors = errors + 1;
        end
    endtask

    task automatic compare_nowa(input adc_ctrl_pkg::nowa_t got, input adc_ctrl_pkg::nowa_t exp,
                                input string what);
        if (got !== exp) begin
            $display("MISMATCH at %0t: %s got %h expected %h", $time, what, got, exp);
            errors = errors + 1;
        end
    endtask

    task automatic compare_bit(input logic got, input logic exp, input string what);
        if (got !== exp) begin
            $display("MISMATCH at %0t: %s got %b expected %b", $time, what, got, exp);
            errors = errors + 1;
        end
    endtask

    task automatic compare_count(input adc_ctrl_pkg::count_t got,
                                 input adc_ctrl_pkg::count_t exp, input string what);
        if (got !== exp) begin
            $display("MISMATCH at %0t: %s got %0d expected %0d", $time, what, got, exp);
            errors = errors + 1;
        end
    endtask

    // chip model, each enable answered by a burst of acknowledges
    always begin
        @(negedge clk);
        if (adc_ena) begin
            for (int i = 0; i < adc_ctrl_pkg::samples_per_ena; i++) begin
                @(posedge clk);
                chip_val = adc_ctrl_pkg::sample_t'($random(seed));
                adc_dout <= chip_val;
                // alternate the two ack lines
                if (i % 2 == 0) begin
                    adc_ack <= 1'b1;
                end else begin
                    adc_ack_sub <= 1'b1;
                end
                exp_q.push_back(chip_val);
                samples_sent = samples_sent + 1;
                @(posedge clk);
                @(posedge clk);
                adc_ack <= 1'b0;
                adc_ack_sub <= 1'b0;
                @(posedge clk);
            end
        end
    end

    // enable pulse spacing, measured from the first run cycle
    always @(negedge clk) begin
        cyc = cyc + 1;
        in_run = (state == adc_ctrl_pkg::calib) || (state == adc_ctrl_pkg::sample);
        if (in_run && !was_run) begin
            last_ena = cyc;
            ena_seen = 0;
        end
        was_run = in_run;
        if (adc_ena) begin
            compare_count(adc_ctrl_pkg::count_t'(cyc - last_ena),
                          adc_ctrl_pkg::count_t'(adc_ctrl_pkg::ena_period), "adc_ena spacing");
            compare_bit(adc_calib_ena, exp_calib, "adc_calib_ena at enable");
            last_ena = cyc;
            ena_seen = ena_seen + 1;
        end
    end

    // spi word checker, oldest sample in the top bits
    always @(negedge clk) begin
        if (spi_wreq) begin
            if (exp_q.size() < adc_ctrl_pkg::samples_per_word) begin
                $display("spi word at %0t came before its 16 samples were sent", $time);
                errors = errors + 1;
            end else begin
                exp_word = '0;
                for (int i = 0; i < adc_ctrl_pkg::samples_per_word; i++) begin
                    exp_word = {exp_word[adc_ctrl_pkg::spi_word_w-adc_ctrl_pkg::sample_w-1:0],
                                exp_q.pop_front()};
                end
                compare_word(spi_wdata, exp_word, "spi_wdata");
            end
            words_seen = words_seen + 1;
            owed = owed + 1;
        end
    end

    // spi side returns one credit a few cycles after each word
    always @(posedge clk) begin
        if (credit_en && owed > 0) begin
            if (credit_wait == 3) begin
                spi_credit <= 1'b1;
                owed = owed - 1;
                credit_wait = 0;
            end else begin
                spi_credit <= 1'b0;
                credit_wait = credit_wait + 1;
            end
        end else begin
            spi_credit <= 1'b0;
            credit_wait = 0;
        end
    end

    // ends at the first cycle with adc_rstn high again
    task automatic count_reset_low();
        int n;
        n = 0;
        while (!adc_rstn && n < reset_budget) begin
            n = n + 1;
            @(negedge clk);
        end
        compare_count(adc_ctrl_pkg::count_t'(n),
                      adc_ctrl_pkg::count_t'(adc_ctrl_pkg::reset_cycles), "adc_rstn low cycles");
    endtask

    task automatic run_command(input logic [7:0] code, input adc_ctrl_pkg::seq_state_t next);
        int n;
        @(posedge clk);
        uart_rdata <= code;
        uart_vld <= 1'b1;
        @(posedge clk);
        uart_vld <= 1'b0;
        @(negedge clk);
        compare_state(state, adc_ctrl_pkg::hold, "state while cmd_valid");
        @(negedge clk);
        n = 0;
        while (state == adc_ctrl_pkg::pre_delay && n < pre_budget) begin
            n = n + 1;
            @(negedge clk);
        end
        compare_count(adc_ctrl_pkg::count_t'(n),
                      adc_ctrl_pkg::count_t'(adc_ctrl_pkg::pre_delay_cycles), "pre_delay cycles");
        compare_state(state, next, "state after pre_delay");
    endtask

    task automatic wait_run_end(input int limit);
        int n;
        n = 0;
        while ((state == adc_ctrl_pkg::calib || state == adc_ctrl_pkg::sample) && n < limit) begin
            n = n + 1;
            @(negedge clk);
        end
        if (n >= limit) begin
            $display("run did not finish within %0d cycles at %0t", limit, $time);
            errors = errors + 1;
        end
    endtask

    task automatic check_run_end(input int enables, input int words_before);
        compare_state(state, adc_ctrl_pkg::hold, "state after run");
        compare_count(adc_ctrl_pkg::count_t'(ena_seen), adc_ctrl_pkg::count_t'(enables),
                      "enable pulses");
        compare_count(adc_ctrl_pkg::count_t'(words_seen - words_before),
                      adc_ctrl_pkg::count_t'(enables * adc_ctrl_pkg::samples_per_ena
                                             / adc_ctrl_pkg::samples_per_word), "spi words");
        compare_count(adc_ctrl_pkg::count_t'(exp_q.size()), '0, "samples left over");
        compare_count(adc_ctrl_pkg::count_t'(owed), '0, "credits still owed");
        compare_bit(spi_overrun, 1'b0, "spi_overrun");
    endtask

    task automatic test_reset_phase();
        @(negedge clk);
        compare_state(state, adc_ctrl_pkg::idle, "state before lock");
        compare_bit(adc_rstn, 1'b1, "adc_rstn before lock");
        compare_bit(adc_ena, 1'b0, "adc_ena before lock");
        compare_bit(spi_wreq, 1'b0, "spi_wreq before lock");
        @(posedge clk);
        pll_locked <= 1'b1;
        @(negedge clk);
        compare_state(state, adc_ctrl_pkg::idle, "state in lock cycle");
        @(negedge clk);
        compare_bit(adc_rstn, 1'b0, "adc_rstn one cycle after lock");
        count_reset_low();
        compare_state(state, adc_ctrl_pkg::hold, "state after adc reset");
        compare_nowa(adc_nowa, sw_nowa, "adc_nowa");
    endtask

    task automatic test_calib_run();
        int words_before;
        words_before = words_seen;
        exp_calib = 1'b1;
        run_command({4'ha, adc_ctrl_pkg::cmd_calib}, adc_ctrl_pkg::calib);
        compare_bit(adc_calib_ena, 1'b1, "adc_calib_ena in calib");
        wait_run_end(calib_budget);
        check_run_end(adc_ctrl_pkg::calib_enables, words_before);
        compare_bit(adc_calib_ena, 1'b0, "adc_calib_ena after calib");
    endtask

    task automatic test_sample_run();
        int words_before;
        words_before = words_seen;
        exp_calib = 1'b0;
        run_command({4'h5, adc_ctrl_pkg::cmd_sample}, adc_ctrl_pkg::sample);
        compare_bit(adc_calib_ena, 1'b0, "adc_calib_ena in sample");
        wait_run_end(sample_budget);
        check_run_end(adc_ctrl_pkg::sample_enables, words_before);
    endtask

    task automatic test_bad_command();
        @(posedge clk);
        sw_nowa <= 9'h0a7;
        run_command(8'h07, adc_ctrl_pkg::adc_reset);
        count_reset_low();
        compare_state(state, adc_ctrl_pkg::hold, "state after second reset");
        compare_nowa(adc_nowa, 9'h0a7, "adc_nowa relatched");
    endtask

    task automatic test_back_pressure();
        int words_before;
        int base;
        int n;
        words_before = words_seen;
        base = samples_sent;
        exp_calib = 1'b0;
        credit_en = 1'b0;
        run_command({4'h3, adc_ctrl_pkg::cmd_sample}, adc_ctrl_pkg::sample);
        // let a third word complete while both credits are out
        n = 0;
        while (samples_sent - base < 3 * adc_ctrl_pkg::samples_per_word && n < sample_budget) begin
            n = n + 1;
            @(negedge clk);
        end
        repeat (10) @(negedge clk);
        compare_count(adc_ctrl_pkg::count_t'(words_seen - words_before),
                      adc_ctrl_pkg::count_t'(adc_ctrl_pkg::spi_credits), "words without credit");
        compare_state(state, adc_ctrl_pkg::sample, "state under back-pressure");
        credit_en = 1'b1;
        wait_run_end(sample_budget);
        check_run_end(adc_ctrl_pkg::sample_enables, words_before);
    endtask

    initial begin
        #(watchdog_cycles * 10);
        $display("watchdog expired after %0d cycles at %0t", watchdog_cycles, $time);
        $display("ERRORS FOUND");
        $finish;
    end

    initial begin
        clk = 1'b0;
        nrst = 1'b0;
        pll_locked = 1'b0;
        sw_nowa = 9'h15a;
        uart_rdata = 8'h00;
        uart_vld = 1'b0;
        adc_ack = 1'b0;
        adc_ack_sub = 1'b0;
        adc_dout = '0;
        spi_credit = 1'b0;
        repeat (8) @(posedge clk);
        nrst <= 1'b1;
        test_reset_phase();
        test_calib_run();
        test_sample_run();
        test_bad_command();
        test_back_pressure();
        $display("%0d errors, %0d spi words checked", errors, words_seen);
        if (errors == 0) begin
            $display("NO ERRORS");
        end else begin
            $display("ERRORS FOUND");
        end
        $finish;
    end

endmodule

// File: build.f
adc_ctrl_pkg.sv
uart_cmd_decoder.sv
adc_strobe_gen.sv
sample_packer.sv
test_sequencer.sv
adc_ctrl_top.sv
adc_ctrl_tb.sv

// File: Makefile
SHELL := /bin/bash

VERILATOR ?= verilator
TOP       ?= adc_ctrl_tb
FILELIST  ?= build.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -j 0
FAIL_MSG  ?= ERRORS FOUND

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator, run the testbench, check $(LOG)"
	@echo "  clean  remove $(OBJ_DIR) and $(LOG)"
	@echo "variables: VERILATOR TOP FILELIST OBJ_DIR LOG VFLAGS"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR) -o V$(TOP)
	set -o pipefail; ./$(OBJ_DIR)/V$(TOP) | tee $(LOG)
	@if grep -q "$(FAIL_MSG)" $(LOG); then \
		echo "simulation failed, see $(LOG)"; \
		exit 1; \
	fi
	@echo "simulation passed"

clean:
	rm -rf $(OBJ_DIR) $(LOG)
